// File: source/mcd_host_pkg.sv
//////////////////////////////////////////////////
// Shared widths and sequencer states for the Mega-CD
// host services, imported by each block that needs them
//////////////////////////////////////////////////

package mcd_host_pkg;

	//////////////////////////////////////////////////
	// Backup RAM and host sector buffer

	// 8 KB of byte-wide backup RAM
	localparam int BRAM_ADDR_W = 13;

	// 256 words per 512-byte sector
	localparam int BUF_ADDR_W = 8;

	// Sector number as the host sees it
	localparam int LBA_W = 32;

	//////////////////////////////////////////////////
	// CD drive frames

	localparam int CDD_STAT_W = 40;

	// Payload, data-mode flag, padding, toggle on top
	localparam int CDD_FRAME_W = 49;

	//////////////////////////////////////////////////
	// Save/load sequencer

	typedef enum logic [1:0] {
		BK_IDLE,
		// Strobe up, waiting for ack to rise
		BK_REQ,
		// Host moving the sector
		BK_XFER,
		BK_NEXT
	} bk_state_e;

endpackage

// File: source/bram_store.sv
//////////////////////////////////////////////////
// Backup RAM, byte port for the console and word
// port for the host sector buffer, both reads registered
//////////////////////////////////////////////////

module bram_store (
	input  logic                                  clk_sys,
	input  logic [mcd_host_pkg::BRAM_ADDR_W-1:0]  bram_addr,
	input  logic [7:0]                            bram_wdata,
	input  logic                                  bram_we,
	input  logic [3:0]                            sect_sel,
	input  logic [mcd_host_pkg::BUF_ADDR_W-1:0]   sd_buff_addr,
	input  logic [15:0]                           sd_buff_dout,
	input  logic                                  host_we,
	output logic [7:0]                            bram_rdata,
	output logic [15:0]                           sd_buff_din
);
	import mcd_host_pkg::*;

	// Even bytes in lane 0, odd bytes in lane 1
	localparam int LANE_AW    = BRAM_ADDR_W - 1;
	localparam int LANE_DEPTH = 1 << LANE_AW;

	logic [LANE_AW-1:0] host_idx;
	logic [LANE_AW-1:0] cons_idx;
	logic               cons_lane_q;

	assign host_idx = {sect_sel, sd_buff_addr};
	assign cons_idx = bram_addr[BRAM_ADDR_W-1:1];

	for (genvar lane = 0; lane < 2; lane++) begin : g_lane
		logic [7:0] mem [LANE_DEPTH];
		logic [7:0] cons_q;
		logic [7:0] host_q;

		always_ff @(posedge clk_sys) begin
			if (bram_we && bram_addr[0] == 1'(lane)) begin
				mem[cons_idx] <= bram_wdata;
			end
			// Host wins a collision on the same byte
			if (host_we) begin
				mem[host_idx] <= sd_buff_dout[8*lane +: 8];
			end
			cons_q <= mem[cons_idx];
			host_q <= mem[host_idx];
		end
	end

	// Byte select travels with the read data
	always_ff @(posedge clk_sys) begin
		cons_lane_q <= bram_addr[0];
	end

	assign bram_rdata  = cons_lane_q ? g_lane[1].cons_q : g_lane[0].cons_q;
	assign sd_buff_din = {g_lane[1].host_q, g_lane[0].host_q};

endmodule

// File: source/bram_sync.sv
//////////////////////////////////////////////////
// Backup RAM save/load sequencer, moves the RAM sector
// by sector to or from the mounted save image
//////////////////////////////////////////////////

module bram_sync #(
	parameter int SECTOR_COUNT = 16
) (
	input  logic                            clk_sys,
	input  logic                            arst_n,
	input  logic                            img_mounted,
	input  logic                            img_readonly,
	input  logic                            load_req,
	input  logic                            save_req,
	input  logic                            autosave,
	input  logic                            osd_open,
	input  logic                            bram_we,
	input  logic                            sd_ack,
	input  logic                            sd_buff_wr,
	output logic [mcd_host_pkg::LBA_W-1:0]  sd_lba,
	output logic                            sd_rd,
	output logic                            sd_wr,
	output logic                            host_we,
	output logic                            bk_busy,
	output logic                            bk_loading,
	output logic                            sav_pending
);
	import mcd_host_pkg::*;

	localparam logic [LBA_W-1:0] LAST_LBA = LBA_W'(SECTOR_COUNT - 1);

	bk_state_e state;
	logic      bk_ena;

	logic load_req_d;
	logic save_req_d;
	logic osd_open_d;
	logic bram_we_d;
	logic sd_ack_d;

	logic ack_rise;
	logic ack_fall;
	logic mount_load;
	logic user_load;
	logic user_save;
	logic auto_save;
	logic start_load;
	logic start;

	//////////////////////////////////////////////////
	// Trigger edges

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			load_req_d <= 1'b0;
			save_req_d <= 1'b0;
			osd_open_d <= 1'b0;
			bram_we_d  <= 1'b0;
			sd_ack_d   <= 1'b0;
		end else begin
			load_req_d <= load_req;
			save_req_d <= save_req;
			osd_open_d <= osd_open;
			bram_we_d  <= bram_we;
			sd_ack_d   <= sd_ack;
		end
	end

	assign ack_rise = sd_ack & ~sd_ack_d;
	assign ack_fall = ~sd_ack & sd_ack_d;

	// A writable mount loads at once, before the enable settles
	assign mount_load = img_mounted & ~img_readonly;
	assign user_load  = bk_ena & load_req & ~load_req_d;
	assign user_save  = bk_ena & save_req & ~save_req_d;
	assign auto_save  = bk_ena & autosave & osd_open & ~osd_open_d & sav_pending;
	assign start_load = mount_load | user_load;

	// Anything arriving while busy is dropped
	assign start = (state == BK_IDLE) & (start_load | user_save | auto_save);

	//////////////////////////////////////////////////
	// Image enable and change tracking

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			bk_ena      <= 1'b0;
			sav_pending <= 1'b0;
		end else begin
			if (img_mounted) begin
				bk_ena <= ~img_readonly;
			end
			// Console write during a save keeps the flag
			if (bram_we & ~bram_we_d) begin
				sav_pending <= 1'b1;
			end else if (start) begin
				sav_pending <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Sector loop

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state      <= BK_IDLE;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			case (state)
				BK_IDLE: begin
					if (start) begin
						sd_lba     <= '0;
						sd_rd      <= start_load;
						sd_wr      <= ~start_load;
						bk_busy    <= 1'b1;
						bk_loading <= start_load;
						state      <= BK_REQ;
					end
				end
				BK_REQ: begin
					// Host has taken the request
					if (ack_rise) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= BK_XFER;
					end
				end
				BK_XFER: begin
					if (ack_fall) begin
						state <= BK_NEXT;
					end
				end
				BK_NEXT: begin
					if (sd_lba == LAST_LBA) begin
						bk_busy    <= 1'b0;
						bk_loading <= 1'b0;
						state      <= BK_IDLE;
					end else begin
						sd_lba <= sd_lba + 1'b1;
						sd_rd  <= bk_loading;
						sd_wr  <= ~bk_loading;
						state  <= BK_REQ;
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

	// Host buffer writes reach the RAM only on a load
	assign host_we = sd_buff_wr & sd_ack & bk_loading;

endmodule

// File: source/cdd_bridge.sv
//////////////////////////////////////////////////
// CD drive message bridge, toggle-marked status in
// from the host and command frames out to it
//////////////////////////////////////////////////

module cdd_bridge #(
	parameter int REC_PULSE_CYCLES = 8
) (
	input  logic                                  clk_sys,
	input  logic                                  arst_n,
	input  logic [mcd_host_pkg::CDD_FRAME_W-1:0]  cd_out,
	input  logic                                  cdd_send,
	input  logic [mcd_host_pkg::CDD_STAT_W-1:0]   cdd_comm,
	output logic [mcd_host_pkg::CDD_FRAME_W-1:0]  cd_in,
	output logic [mcd_host_pkg::CDD_STAT_W-1:0]   cdd_stat,
	output logic                                  cdd_dm,
	output logic                                  cdd_rec
);
	import mcd_host_pkg::*;

	localparam int TOGGLE_BIT = CDD_FRAME_W - 1;
	localparam int DM_BIT     = CDD_STAT_W;
	localparam int PAD_W      = CDD_FRAME_W - CDD_STAT_W - 1;
	localparam int CNT_W      = $clog2(REC_PULSE_CYCLES + 1);

	localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(REC_PULSE_CYCLES - 1);

	logic             toggle_last;
	logic             new_frame;
	logic [CNT_W-1:0] rec_cnt;
	logic             send_d;
	logic             send_rise;

	assign new_frame = cd_out[TOGGLE_BIT] ^ toggle_last;
	assign send_rise = cdd_send & ~send_d;

	//////////////////////////////////////////////////
	// Inbound status

	// Strobe rises with the latch and is stretched by the counter
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			toggle_last <= 1'b0;
			cdd_rec     <= 1'b0;
			rec_cnt     <= '0;
		end else if (new_frame) begin
			toggle_last <= cd_out[TOGGLE_BIT];
			cdd_rec     <= 1'b1;
			rec_cnt     <= CNT_LOAD;
		end else if (rec_cnt != '0) begin
			rec_cnt <= rec_cnt - 1'b1;
		end else begin
			cdd_rec <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (new_frame) begin
			cdd_stat <= cd_out[CDD_STAT_W-1:0];
			cdd_dm   <= cd_out[DM_BIT];
		end
	end

	//////////////////////////////////////////////////
	// Outbound commands

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			send_d <= 1'b0;
			cd_in  <= '0;
		end else begin
			send_d <= cdd_send;
			// Flipped toggle tells the host a new frame is waiting
			if (send_rise) begin
				cd_in <= {~cd_in[TOGGLE_BIT], {PAD_W{1'b0}}, cdd_comm};
			end
		end
	end

endmodule

// File: source/mcd_host_top.sv
//////////////////////////////////////////////////
// Host services top, backup RAM store with its
// save/load sequencer and the CD drive bridge
//////////////////////////////////////////////////

module mcd_host_top #(
	parameter int SECTOR_COUNT     = 16,
	parameter int REC_PULSE_CYCLES = 8
) (
	input  logic                                  clk_sys,
	input  logic                                  arst_n,
	input  logic [mcd_host_pkg::BRAM_ADDR_W-1:0]  bram_addr,
	input  logic [7:0]                            bram_wdata,
	input  logic                                  bram_we,
	input  logic                                  img_mounted,
	input  logic                                  img_readonly,
	input  logic                                  load_req,
	input  logic                                  save_req,
	input  logic                                  autosave,
	input  logic                                  osd_open,
	input  logic                                  sd_ack,
	input  logic [mcd_host_pkg::BUF_ADDR_W-1:0]   sd_buff_addr,
	input  logic [15:0]                           sd_buff_dout,
	input  logic                                  sd_buff_wr,
	input  logic [mcd_host_pkg::CDD_FRAME_W-1:0]  cd_out,
	input  logic                                  cdd_send,
	input  logic [mcd_host_pkg::CDD_STAT_W-1:0]   cdd_comm,
	output logic [7:0]                            bram_rdata,
	output logic [mcd_host_pkg::LBA_W-1:0]        sd_lba,
	output logic                                  sd_rd,
	output logic                                  sd_wr,
	output logic [15:0]                           sd_buff_din,
	output logic                                  bk_busy,
	output logic                                  bk_loading,
	output logic                                  sav_pending,
	output logic [mcd_host_pkg::CDD_FRAME_W-1:0]  cd_in,
	output logic [mcd_host_pkg::CDD_STAT_W-1:0]   cdd_stat,
	output logic                                  cdd_dm,
	output logic                                  cdd_rec
);
	import mcd_host_pkg::*;

	// Sector bits of the LBA pick the RAM page
	localparam int SECT_W = BRAM_ADDR_W - BUF_ADDR_W - 1;

	logic host_we;

	bram_store u_store (
		.clk_sys      (clk_sys),
		.bram_addr    (bram_addr),
		.bram_wdata   (bram_wdata),
		.bram_we      (bram_we),
		.sect_sel     (sd_lba[SECT_W-1:0]),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.host_we      (host_we),
		.bram_rdata   (bram_rdata),
		.sd_buff_din  (sd_buff_din)
	);

	bram_sync #(
		.SECTOR_COUNT (SECTOR_COUNT)
	) u_sync (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.load_req     (load_req),
		.save_req     (save_req),
		.autosave     (autosave),
		.osd_open     (osd_open),
		.bram_we      (bram_we),
		.sd_ack       (sd_ack),
		.sd_buff_wr   (sd_buff_wr),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.host_we      (host_we),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading),
		.sav_pending  (sav_pending)
	);

	cdd_bridge #(
		.REC_PULSE_CYCLES (REC_PULSE_CYCLES)
	) u_cdd (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.cd_out   (cd_out),
		.cdd_send (cdd_send),
		.cdd_comm (cdd_comm),
		.cd_in    (cd_in),
		.cdd_stat (cdd_stat),
		.cdd_dm   (cdd_dm),
		.cdd_rec  (cdd_rec)
	);

endmodule

// File: tb/mcd_host_asserts.sv
//////////////////////////////////////////////////
// Concurrent checks on the sequencer strobes and the
// drive receive pulse, bound into the design blocks
//////////////////////////////////////////////////

module mcd_host_asserts #(
	parameter int REC_PULSE_CYCLES = 8
) (
	input logic                    clk_sys,
	input logic                    arst_n,
	input logic                    sd_rd,
	input logic                    sd_wr,
	input logic                    bk_busy,
	input mcd_host_pkg::bk_state_e state,
	input logic                    cdd_rec
);
	timeunit 1ns;
	timeprecision 1ps;

	import mcd_host_pkg::*;

	// Length of the receive pulse so far
	int rec_len;

	// Failed assertions so far
	int fail_cnt = 0;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rec_len <= 0;
		end else if (cdd_rec) begin
			rec_len <= rec_len + 1;
		end else begin
			rec_len <= 0;
		end
	end

	rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(sd_rd && sd_wr))
		else begin
			$error("sd_rd and sd_wr high together");
			fail_cnt++;
		end

	idle_not_busy: assert property (@(posedge clk_sys) disable iff (!arst_n)
		state == BK_IDLE |-> !bk_busy)
		else begin
			$error("bk_busy high while the sequencer is idle");
			fail_cnt++;
		end

	rec_pulse_len: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$fell(cdd_rec) |-> rec_len == REC_PULSE_CYCLES)
		else begin
			$error("cdd_rec pulse lasted %0d cycles", rec_len);
			fail_cnt++;
		end

endmodule

bind bram_sync mcd_host_asserts u_sync_asserts (.*, .cdd_rec (1'b0));

bind cdd_bridge mcd_host_asserts #(
	.REC_PULSE_CYCLES (REC_PULSE_CYCLES)
) u_cdd_asserts (.*, .sd_rd (1'b0), .sd_wr (1'b0), .bk_busy (1'b0),
	.state (mcd_host_pkg::BK_IDLE));

// File: tb/mcd_host_tb.sv
//////////////////////////////////////////////////
// Testbench for the host services top, replays the
// vector file against a host sector model and checks
//////////////////////////////////////////////////

module mcd_host_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import mcd_host_pkg::*;

	localparam int    SECTOR_COUNT     = 16;
	localparam int    REC_PULSE_CYCLES = 8;
	localparam int    SECTOR_WORDS     = 1 << BUF_ADDR_W;
	localparam int    QUIET_CYCLES     = 2000;
	// 40 sectors of 600 cycles plus slack
	localparam int    CYCLE_LIMIT      = 40 * 600 + 2000;
	localparam string VEC_FILE         = "tb/mcd_host_vectors.txt";

	logic                   clk_sys;
	logic                   arst_n;
	logic [BRAM_ADDR_W-1:0] bram_addr;
	logic [7:0]             bram_wdata;
	logic                   bram_we;
	logic                   img_mounted;
	logic                   img_readonly;
	logic                   load_req;
	logic                   save_req;
	logic                   autosave;
	logic                   osd_open;
	logic                   sd_ack;
	logic [BUF_ADDR_W-1:0]  sd_buff_addr;
	logic [15:0]            sd_buff_dout;
	logic                   sd_buff_wr;
	logic [CDD_FRAME_W-1:0] cd_out;
	logic                   cdd_send;
	logic [CDD_STAT_W-1:0]  cdd_comm;
	logic [7:0]             bram_rdata;
	logic [LBA_W-1:0]       sd_lba;
	logic                   sd_rd;
	logic                   sd_wr;
	logic [15:0]            sd_buff_din;
	logic                   bk_busy;
	logic                   bk_loading;
	logic                   sav_pending;
	logic [CDD_FRAME_W-1:0] cd_in;
	logic [CDD_STAT_W-1:0]  cdd_stat;
	logic                   cdd_dm;
	logic                   cdd_rec;

	// Expected RAM contents after host loads and console writes
	logic [7:0] model_ram [1 << BRAM_ADDR_W];
	integer     seed;
	int         cycle_cnt = 0;
	logic       out_toggle;
	logic       in_toggle;

	mcd_host_top #(
		.SECTOR_COUNT     (SECTOR_COUNT),
		.REC_PULSE_CYCLES (REC_PULSE_CYCLES)
	) uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
			$display("Checks failed");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic check(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("error %s expected %h actual %h", name, expected, actual);
			$display("Checks failed");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// Failures seen so far by both bound checkers
	function automatic int bound_fail_count();
		return uut.u_sync.u_sync_asserts.fail_cnt + uut.u_cdd.u_cdd_asserts.fail_cnt;
	endfunction

	always @(negedge clk_sys) begin
		if (bound_fail_count() != 0) begin
			$display("A bound assertion on the design failed");
			$display("Checks failed");
			$fatal(1, "assertion failure");
		end
	end

	// Host image word, every word address bit shows up in the data
	function automatic logic [15:0] image_word(input logic [15:0] seed_word,
		input logic [11:0] word_addr);
		return seed_word ^ {4'h0, word_addr};
	endfunction

	//////////////////////////////////////////////////
	// Host sector model

	task automatic serve_sector(input string name, input bit is_load, input int sector,
		input logic [15:0] seed_word);
		int          delay;
		int          idx;
		logic [11:0] base;
		logic [15:0] word;
		while (!sd_rd && !sd_wr) begin
			@(negedge clk_sys);
		end
		check(name, 64'(is_load), 64'(sd_rd));
		check(name, 64'(!is_load), 64'(sd_wr));
		check(name, 64'(sector), 64'(sd_lba));
		check(name, 64'(is_load), 64'(bk_loading));
		check(name, 64'd1, 64'(bk_busy));
		delay = 1 + ($random(seed) & 7);
		repeat (delay) @(negedge clk_sys);
		sd_ack = 1'b1;
		base = {4'(sector), 8'h00};
		if (is_load) begin
			for (int w = 0; w < SECTOR_WORDS; w++) begin
				word = image_word(seed_word, base | 12'(w));
				idx  = 2 * (int'(base) + w);
				sd_buff_addr = BUF_ADDR_W'(w);
				sd_buff_dout = word;
				sd_buff_wr   = 1'b1;
				model_ram[idx]     = word[7:0];
				model_ram[idx + 1] = word[15:8];
				@(negedge clk_sys);
			end
			sd_buff_wr = 1'b0;
		end else begin
			// Read data trails the address by one cycle
			for (int w = 0; w <= SECTOR_WORDS; w++) begin
				if (w > 0) begin
					idx = 2 * (int'(base) + w - 1);
					check(name, 64'({model_ram[idx + 1], model_ram[idx]}), 64'(sd_buff_din));
				end
				if (w < SECTOR_WORDS) begin
					sd_buff_addr = BUF_ADDR_W'(w);
				end
				@(negedge clk_sys);
			end
		end
		sd_ack = 1'b0;
	endtask

	task automatic serve_image(input string name, input bit is_load,
		input logic [15:0] seed_word);
		for (int s = 0; s < SECTOR_COUNT; s++) begin
			serve_sector(name, is_load, s, seed_word);
		end
		while (bk_busy) begin
			@(negedge clk_sys);
		end
		check(name, 64'd0, 64'(bk_loading));
	endtask

	task automatic expect_no_save(input string name);
		repeat (QUIET_CYCLES) begin
			@(negedge clk_sys);
			check(name, 64'd0, 64'(sd_wr));
		end
	endtask

	//////////////////////////////////////////////////
	// Console, triggers and drive frames

	task automatic console_write(input logic [BRAM_ADDR_W-1:0] addr, input logic [7:0] data);
		bram_addr  = addr;
		bram_wdata = data;
		bram_we    = 1'b1;
		@(negedge clk_sys);
		bram_we = 1'b0;
		model_ram[addr] = data;
		@(negedge clk_sys);
	endtask

	task automatic console_read(input string name, input logic [BRAM_ADDR_W-1:0] addr,
		input logic [7:0] expected);
		bram_addr = addr;
		@(negedge clk_sys);
		check(name, 64'(expected), 64'(bram_rdata));
	endtask

	task automatic mount_image(input bit readonly);
		img_readonly = readonly;
		img_mounted  = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b0;
	endtask

	task automatic cdd_receive(input string name, input logic [CDD_STAT_W-1:0] stat,
		input logic dm);
		int high_cycles;
		high_cycles = 0;
		out_toggle  = ~out_toggle;
		cd_out      = {out_toggle, 7'h00, dm, stat};
		@(negedge clk_sys);
		check(name, 64'(stat), 64'(cdd_stat));
		check(name, 64'(dm), 64'(cdd_dm));
		while (cdd_rec && high_cycles < 4 * REC_PULSE_CYCLES) begin
			high_cycles++;
			@(negedge clk_sys);
		end
		check(name, 64'(REC_PULSE_CYCLES), 64'(high_cycles));
	endtask

	task automatic cdd_command(input string name, input logic [CDD_STAT_W-1:0] comm);
		cdd_comm  = comm;
		cdd_send  = 1'b1;
		in_toggle = ~in_toggle;
		@(negedge clk_sys);
		check(name, 64'({in_toggle, 8'h00, comm}), 64'(cd_in));
		cdd_send = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic run_record(input string name, input string op, input logic [63:0] arg_a,
		input logic [63:0] arg_b);
		case (op)
			"reset": begin
				check(name, 64'd0, 64'(sd_rd));
				check(name, 64'd0, 64'(sd_wr));
				check(name, 64'd0, 64'(bk_busy));
				check(name, 64'd0, 64'(bk_loading));
				check(name, 64'd0, 64'(sav_pending));
				check(name, 64'd0, 64'(cdd_rec));
				check(name, 64'd0, 64'(cd_in));
			end
			"mount": begin
				mount_image(1'b0);
				serve_image(name, 1'b1, arg_a[15:0]);
			end
			"mount_ro":   mount_image(1'b1);
			"read":       console_read(name, arg_a[BRAM_ADDR_W-1:0], arg_b[7:0]);
			"write":      console_write(arg_a[BRAM_ADDR_W-1:0], arg_b[7:0]);
			"pending":    check(name, arg_a, 64'(sav_pending));
			"autosave":   autosave = arg_a[0];
			"save", "save_quiet": begin
				save_req = 1'b1;
				@(negedge clk_sys);
				save_req = 1'b0;
				if (op == "save") begin
					serve_image(name, 1'b0, 16'h0000);
				end else begin
					expect_no_save(name);
				end
			end
			"osd_save", "osd_quiet": begin
				osd_open = 1'b1;
				@(negedge clk_sys);
				osd_open = 1'b0;
				if (op == "osd_save") begin
					serve_image(name, 1'b0, 16'h0000);
				end else begin
					expect_no_save(name);
				end
			end
			"cdd_rx":     cdd_receive(name, arg_a[CDD_STAT_W-1:0], arg_b[0]);
			"cdd_tx":     cdd_command(name, arg_a[CDD_STAT_W-1:0]);
			default: begin
				$display("Unknown operation %s in record %s of the vector file", op, name);
				$display("Checks failed");
				$fatal(1, "bad vector record");
			end
		endcase
	endtask

	initial begin
		int          fd;
		int          status;
		int          n;
		int          records;
		string       line;
		string       name;
		string       op;
		logic [63:0] arg_a;
		logic [63:0] arg_b;
		seed         = 32'h67df472a;
		records      = 0;
		out_toggle   = 1'b0;
		in_toggle    = 1'b0;
		arst_n       = 1'b0;
		bram_addr    = '0;
		bram_wdata   = '0;
		bram_we      = 1'b0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		load_req     = 1'b0;
		save_req     = 1'b0;
		autosave     = 1'b0;
		osd_open     = 1'b0;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		cd_out       = '0;
		cdd_send     = 1'b0;
		cdd_comm     = '0;
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		arst_n = 1'b1;
		@(negedge clk_sys);
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open the vector file %s", VEC_FILE);
			$display("Checks failed");
			$fatal(1, "no stimulus");
		end
		while (!$feof(fd)) begin
			status = $fgets(line, fd);
			if (status != 0) begin
				n = $sscanf(line, "%s %s %h %h", name, op, arg_a, arg_b);
				// Lines starting with a hash are column notes
				if (n == 4 && name.substr(0, 0) != "#") begin
					run_record(name, op, arg_a, arg_b);
					records++;
				end
			end
		end
		$fclose(fd);
		if (records == 0) begin
			$display("The vector file held no records");
			$display("Checks failed");
			$fatal(1, "empty stimulus");
		end else if (bound_fail_count() != 0) begin
			$display("A bound assertion on the design failed");
			$display("Checks failed");
			$fatal(1, "assertion failure");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

// File: tb/mcd_host_vectors.txt
# name  operation  arg_a (hex)  arg_b (hex)
# read/write: byte address, byte; mount: image seed word; cdd_rx: status, data mode
reset_state    reset       0           0
mount_load     mount       3c00        0
rd_byte_0000   read        0000        00
rd_byte_0001   read        0001        3c
rd_byte_0202   read        0202        01
rd_byte_0203   read        0203        3d
rd_byte_0a54   read        0a54        2a
rd_byte_0a55   read        0a55        39
rd_byte_1234   read        1234        1a
rd_byte_1ffe   read        1ffe        ff
rd_byte_1fff   read        1fff        33
wr_byte_0010   write       0010        a7
wr_byte_1ffe   write       1ffe        5b
pend_set       pending     1           0
rd_back_0010   read        0010        a7
save_all       save        0           0
pend_clear     pending     0           0
autosave_on    autosave    1           0
osd_unchanged  osd_quiet   0           0
wr_byte_0800   write       0800        c3
pend_again     pending     1           0
osd_autosave   osd_save    0           0
pend_done      pending     0           0
mount_ro       mount_ro    0           0
ro_save        save_quiet  0           0
cdd_rx_dm      cdd_rx      123456789a  1
cdd_rx_plain   cdd_rx      0f0e0d0c0b  0
cdd_tx_first   cdd_tx      8899aabbcc  0
cdd_tx_second  cdd_tx      0102030405  0

// File: build.f
source/mcd_host_pkg.sv
source/bram_store.sv
source/bram_sync.sv
source/cdd_bridge.sv
source/mcd_host_top.sv
tb/mcd_host_asserts.sv
tb/mcd_host_tb.sv

// File: Makefile
TOOL  := verilator
FLAGS := --binary --timing --assert
TOP   := mcd_host_tb
FLIST := build.f
OBJ   := obj_dir
PASS  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ)

# Pass only when the simulation prints the pass line
run: build
	@out=$$(./$(OBJ)/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -q "$(PASS)"

lint:
	$(TOOL) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ)
